// File: dma_req_pkg.sv
// ********************************************************************
// shared widths, beat layout and arbiter state encoding
// ********************************************************************
package dma_req_pkg;

    // beat payload widths
    localparam int DMA_DATA_W   = 64;   // data bus width in bits
    localparam int DMA_KEEP_W   = 8;    // one keep bit per data byte
    localparam int AXIS_TUSER_W = 128;  // request side-band, only first beat meaningful

    typedef logic [DMA_DATA_W-1:0]   dma_data_t;   // beat payload
    typedef logic [DMA_KEEP_W-1:0]   dma_keep_t;   // byte enables
    typedef logic [AXIS_TUSER_W-1:0] req_tuser_t;  // request descriptor, not decoded here

    // one request beat without its valid bit
    // user layout, as carried in the first beat of a request packet:
    //   127:108 reserved, 107:104 req type, 103:96 tag, 95:32 address,
    //   31:19 reserved, 18:8 dw length, 7:4 first be, 3:0 last be
    typedef struct packed {
        logic       last;  // final beat of the packet
        dma_data_t  data;
        req_tuser_t user;
        dma_keep_t  keep;
    } req_beat_t;

    // arbiter states, one-hot
    typedef enum logic [2:0] {
        IDLE      = 3'b001,  // nothing pending
        SCHEDULE  = 3'b010,  // pick next channel, single-beat packets finish here
        REQ_TRANS = 3'b100   // multi-beat packet in flight, grant frozen
    } arb_state_t;

endpackage

// File: req_rr_select.sv
`timescale 1ns/1ns

// ********************************************************************
// round-robin channel search
// ********************************************************************
// position k of the rotated valid vector stands for channel
// last_chnl + k + 1 (mod CHANNEL_NUM), so position 0 has top priority
// and the channel served last ends up at the lowest priority

module req_rr_select #(
    parameter int CHANNEL_NUM = 4  // number of request sources
) (
    input  logic                   dma_clk,
    input  logic                   rst_n,

    input  logic [CHANNEL_NUM-1:0] s_req_valid,  // raw channel valids
    input  logic                   req_last,     // last beat of a packet accepted
    input  logic [IDX_W-1:0]       grant_idx,    // channel currently granted

    output logic [IDX_W-1:0]       rr_idx,       // search result
    output logic                   any_valid     // at least one channel requesting
);

    localparam int IDX_W = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1;

    logic [IDX_W-1:0]       last_chnl;  // channel granted for the previous packet
    logic [CHANNEL_NUM-1:0] hit_prio;   // valids reordered by priority

    // channel that sits at priority position k behind last_c
    function automatic logic [IDX_W-1:0] chnl_of(input logic [IDX_W-1:0] last_c,
                                                 input int k);
        int sum;
        sum = int'(last_c) + k + 1;
        if (sum >= CHANNEL_NUM)
            sum = sum - CHANNEL_NUM;  // wrap, sum never reaches 2*CHANNEL_NUM
        return sum[IDX_W-1:0];
    endfunction

    // last-granted register, follows the grant at every packet end
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_chnl <= '0;  // first search starts at channel 1
        end else if (req_last) begin
            last_chnl <= grant_idx;
        end
    end

    // rotate the valids into priority order
    for (genvar k = 0; k < CHANNEL_NUM; k++) begin : g_rot
        assign hit_prio[k] = s_req_valid[chnl_of(last_chnl, k)];
    end

    // first set position wins, scanning from the back keeps the lowest one
    always_comb begin
        rr_idx = chnl_of(last_chnl, 0);  // nothing valid: point at last+1
        for (int k = CHANNEL_NUM - 1; k >= 0; k--) begin
            if (hit_prio[k])
                rr_idx = chnl_of(last_chnl, k);
        end
    end

    assign any_valid = |s_req_valid;

endmodule

// File: req_arb_fsm.sv
`timescale 1ns/1ns

// ********************************************************************
// arbitration FSM, idle -> schedule -> request transfer
// ********************************************************************
// SCHEDULE drives the live search result as grant, so a packet can
// start in the same cycle it is picked. a one-beat packet that is
// taken right away never leaves SCHEDULE. a longer packet (or a beat
// stalled by back-pressure) moves to REQ_TRANS with the index frozen

module req_arb_fsm import dma_req_pkg::*; #(
    parameter int CHANNEL_NUM = 4  // number of request sources
) (
    input  logic             dma_clk,
    input  logic             rst_n,

    input  logic             any_valid,    // some channel has a beat
    input  logic             req_last,     // last beat transferred this cycle
    input  logic [IDX_W-1:0] rr_idx,       // round-robin pick

    output logic [IDX_W-1:0] grant_idx,    // channel owning the output
    output logic             grant_active  // output path enabled
);

    localparam int IDX_W = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1;

    arb_state_t       cur_state;
    arb_state_t       nxt_state;
    logic [IDX_W-1:0] held_idx;     // grant kept for the rest of a packet
    logic             j_req_trans;  // schedule -> request transfer

    assign j_req_trans = (cur_state == SCHEDULE) && !req_last && any_valid;

    // ****************************************************************
    // state register
    // ****************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_state <= IDLE;
        end else begin
            cur_state <= nxt_state;
        end
    end

    // ****************************************************************
    // next state
    // ****************************************************************
    always_comb begin
        nxt_state = cur_state;
        case (cur_state)
            IDLE: begin
                if (any_valid)
                    nxt_state = SCHEDULE;  // one cycle of latency from idle
            end
            SCHEDULE: begin
                if (req_last)
                    nxt_state = SCHEDULE;  // single beat already gone, pick again
                else if (any_valid)
                    nxt_state = REQ_TRANS; // packet started or stalled
                else
                    nxt_state = IDLE;
            end
            REQ_TRANS: begin
                if (req_last)
                    nxt_state = SCHEDULE;
            end
            default: nxt_state = IDLE;  // illegal encoding recovers to idle
        endcase
    end

    // ****************************************************************
    // grant index
    // ****************************************************************
    always_ff @(posedge dma_clk or negedge rst_n) begin
        if (!rst_n) begin
            held_idx <= '0;
        end else if (j_req_trans) begin
            held_idx <= rr_idx;  // freeze the pick made in schedule
        end
    end

    assign grant_idx    = (cur_state == SCHEDULE) ? rr_idx : held_idx;
    assign grant_active = (cur_state == SCHEDULE) || (cur_state == REQ_TRANS);

endmodule

// File: req_beat_mux.sv
`timescale 1ns/1ns

// ********************************************************************
// output beat mux and ready steering
// ********************************************************************
// purely combinational. valid and beat of the granted channel go
// straight to the output, downstream ready goes straight back to
// that one channel

module req_beat_mux import dma_req_pkg::*; #(
    parameter int CHANNEL_NUM = 4  // number of request sources
) (
    input  logic [CHANNEL_NUM-1:0] s_req_valid,
    input  req_beat_t              s_req_beat [CHANNEL_NUM],
    input  logic [IDX_W-1:0]       grant_idx,     // selected channel
    input  logic                   grant_active,  // fsm in schedule or transfer
    input  logic                   m_req_ready,   // downstream ready

    output logic [CHANNEL_NUM-1:0] s_req_ready,
    output logic                   m_req_valid,
    output req_beat_t              m_req_beat,
    output logic                   req_last       // last beat accepted
);

    localparam int IDX_W = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1;

    // forward path, zero when no grant is active
    always_comb begin
        m_req_valid = 1'b0;
        m_req_beat  = '0;
        if (grant_active) begin
            m_req_valid = s_req_valid[grant_idx];
            m_req_beat  = s_req_beat[grant_idx];  // last/data/user/keep untouched
        end
    end

    // only the granted channel ever sees ready
    for (genvar n = 0; n < CHANNEL_NUM; n++) begin : g_rdy
        assign s_req_ready[n] = grant_active && (grant_idx == IDX_W'(n)) && m_req_ready;
    end

    // packet end, drives the fsm and the round-robin pointer
    assign req_last = m_req_valid && m_req_ready && m_req_beat.last;

endmodule

// File: req_arbiter.sv
`timescale 1ns/1ns

// ********************************************************************
// round-robin request arbiter for the DMA engine
// ********************************************************************
// merges CHANNEL_NUM packet streams into one. packets are never
// interleaved, a channel keeps the output until its last beat is taken
//
//   req_rr_select : picks the next requesting channel after the last one
//   req_arb_fsm   : idle/schedule/transfer control, holds the grant
//   req_beat_mux  : beat mux towards the output, ready back to the source

module req_arbiter import dma_req_pkg::*; #(
    parameter int CHANNEL_NUM = 4  // number of request sources
) (
    input  logic                   dma_clk,
    input  logic                   rst_n,

    // source side, one stream per channel
    input  logic [CHANNEL_NUM-1:0] s_req_valid,
    input  req_beat_t              s_req_beat [CHANNEL_NUM],
    output logic [CHANNEL_NUM-1:0] s_req_ready,

    // merged request stream
    output logic                   m_req_valid,
    output req_beat_t              m_req_beat,
    input  logic                   m_req_ready
);

    localparam int IDX_W = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1;

    logic [IDX_W-1:0] rr_idx;        // round-robin pick
    logic [IDX_W-1:0] grant_idx;     // current owner of the output
    logic             any_valid;     // some channel requesting
    logic             grant_active;  // schedule or transfer state
    logic             req_last;      // last beat accepted

    // ****************************************************************
    // channel selection
    // ****************************************************************
    req_rr_select #(
        .CHANNEL_NUM (CHANNEL_NUM)
    ) u_rr_select (
        .dma_clk     (dma_clk),
        .rst_n       (rst_n),
        .s_req_valid (s_req_valid),
        .req_last    (req_last),
        .grant_idx   (grant_idx),
        .rr_idx      (rr_idx),
        .any_valid   (any_valid)
    );

    // arbitration control
    req_arb_fsm #(
        .CHANNEL_NUM  (CHANNEL_NUM)
    ) u_arb_fsm (
        .dma_clk      (dma_clk),
        .rst_n        (rst_n),
        .any_valid    (any_valid),
        .req_last     (req_last),
        .rr_idx       (rr_idx),
        .grant_idx    (grant_idx),
        .grant_active (grant_active)
    );

    // ****************************************************************
    // output side
    // ****************************************************************
    req_beat_mux #(
        .CHANNEL_NUM  (CHANNEL_NUM)
    ) u_beat_mux (
        .s_req_valid  (s_req_valid),
        .s_req_beat   (s_req_beat),
        .grant_idx    (grant_idx),
        .grant_active (grant_active),
        .m_req_ready  (m_req_ready),
        .s_req_ready  (s_req_ready),
        .m_req_valid  (m_req_valid),
        .m_req_beat   (m_req_beat),
        .req_last     (req_last)
    );

endmodule

// File: req_arbiter_assert.sv
`timescale 1ns/1ns

module req_arbiter_assert import dma_req_pkg::*; #(
    parameter int CHANNEL_NUM = 4,
    parameter int IDX_W       = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1
) (
    input logic                   dma_clk,
    input logic                   rst_n,
    input logic [CHANNEL_NUM-1:0] s_req_ready,
    input logic                   m_req_valid,
    input logic                   m_req_ready,
    input req_beat_t              m_req_beat,
    input logic [IDX_W-1:0]       grant_idx   // internal grant of the arbiter
);

    // at most one source sees ready
    a_ready_onehot: assert property (@(posedge dma_clk) disable iff (!rst_n)
        $onehot0(s_req_ready))
        else $error("more than one channel ready at once");

    // stall downstream, stall every source
    a_no_ready_stall: assert property (@(posedge dma_clk) disable iff (!rst_n)
        !m_req_ready |-> (s_req_ready == '0))
        else $error("channel ready while downstream is stalled");

    // an open packet keeps its owner until the last beat is taken
    a_grant_hold: assert property (@(posedge dma_clk) disable iff (!rst_n)
        (m_req_valid && !(m_req_ready && m_req_beat.last))
            |=> (grant_idx == $past(grant_idx)))
        else $error("grant moved inside a packet");

endmodule

bind req_arbiter req_arbiter_assert #(
    .CHANNEL_NUM (CHANNEL_NUM)
) u_arb_assert (
    .dma_clk     (dma_clk),
    .rst_n       (rst_n),
    .s_req_ready (s_req_ready),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_beat  (m_req_beat),
    .grant_idx   (grant_idx)
);

// File: tb_req_arbiter.sv
`timescale 1ns/1ns

module tb_req_arbiter import dma_req_pkg::*; ();

    localparam int CHN       = 4;    // channels under test
    localparam int MAX_BEATS = 128;  // source memory depth per channel

    logic           dma_clk;
    logic           rst_n;
    logic [CHN-1:0] s_req_valid;
    req_beat_t      s_req_beat [CHN];
    logic [CHN-1:0] s_req_ready;
    logic           m_req_valid;
    req_beat_t      m_req_beat;
    logic           m_req_ready;

    integer    seed;                      // $random state
    logic      bp_mode;                   // random downstream stalls on
    req_beat_t src_mem [CHN][MAX_BEATS];  // every beat loaded, per channel
    int        wr_ptr  [CHN];             // next free slot
    int        rd_ptr  [CHN];             // beat presented by the source
    int        chk_ptr [CHN];             // beat expected next on the output
    int        pkt_chan [$];              // owner of each output packet, seen on source ready
    logic      in_pkt;                    // output packet open
    int        exp_ch;                    // predicted owner of the open packet
    int        last_exp;                  // model of the last-granted channel

    req_arbiter #(
        .CHANNEL_NUM (CHN)
    ) dut (
        .dma_clk     (dma_clk),
        .rst_n       (rst_n),
        .s_req_valid (s_req_valid),
        .s_req_beat  (s_req_beat),
        .s_req_ready (s_req_ready),
        .m_req_valid (m_req_valid),
        .m_req_beat  (m_req_beat),
        .m_req_ready (m_req_ready)
    );

    always #20 dma_clk = ~dma_clk;  // 40 ns period

    // ******************************************************************
    // helpers
    // ******************************************************************
    task automatic value_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "checker stopped the run");
    endtask

    task automatic timeout_error(input string what);
        $display("timeout while waiting for %s", what);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog stopped the run");
    endtask

    // rotation rule: first valid channel after last_c, last_c itself at the end
    function automatic int next_channel(input int last_c, input logic [CHN-1:0] mask);
        int   c;
        int   pick;
        logic found;
        pick  = last_c;
        found = 1'b0;
        for (int k = 1; k <= CHN; k++) begin
            c = (last_c + k) % CHN;
            if (!found && mask[c]) begin
                pick  = c;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // channel whose ready bit is set, -1 when none
    function automatic int ready_owner(input logic [CHN-1:0] rdy);
        int owner;
        owner = -1;
        for (int c = 0; c < CHN; c++) begin
            if (rdy[c])
                owner = c;
        end
        return owner;
    endfunction

    function automatic req_beat_t rand_beat(input logic last);
        req_beat_t   b;
        logic [31:0] r;
        b.last = last;
        b.data = {$random(seed), $random(seed)};
        b.user = {$random(seed), $random(seed), $random(seed), $random(seed)};
        r      = $random(seed);
        b.keep = r[7:0];
        return b;
    endfunction

    // append n_pkts packets of 1..max_len beats to channel c
    task automatic load_packets(input int c, input int n_pkts, input int max_len);
        int          len;
        logic [31:0] r;
        for (int p = 0; p < n_pkts; p++) begin
            r   = $random(seed);
            len = 1 + int'(r[7:0]) % max_len;
            for (int b = 0; b < len; b++) begin
                src_mem[c][wr_ptr[c]] = rand_beat(b == len - 1);
                wr_ptr[c]++;
            end
        end
    endtask

    function automatic logic all_drained();
        logic done;
        done = !in_pkt;
        for (int c = 0; c < CHN; c++) begin
            if (chk_ptr[c] != wr_ptr[c])
                done = 1'b0;  // beats still owed on this channel
        end
        return done;
    endfunction

    task automatic wait_drain(input int limit, input string what, output int cycles);
        cycles = 0;
        while (!all_drained()) begin
            @(negedge dma_clk);
            cycles++;
            if (cycles > limit)
                timeout_error(what);
        end
    endtask

    task automatic check_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge dma_clk);
            assert (!m_req_valid && s_req_ready == '0)
                else value_error("output active with no request pending");
        end
    endtask

    // ******************************************************************
    // channel sources and downstream ready
    // ******************************************************************
    always @(posedge dma_clk) begin
        for (int c = 0; c < CHN; c++) begin
            if (s_req_valid[c] && s_req_ready[c])
                rd_ptr[c]++;  // beat taken, show the next one
            s_req_valid[c] <= (rd_ptr[c] < wr_ptr[c]);
            s_req_beat[c]  <= (rd_ptr[c] < wr_ptr[c]) ? src_mem[c][rd_ptr[c]] : '0;
        end
        if (bp_mode)
            m_req_ready <= ($random(seed) % 2) == 0;  // about half the cycles stall
        else
            m_req_ready <= 1'b1;
    end

    // ******************************************************************
    // output checker
    // ******************************************************************
    always @(posedge dma_clk) begin
        if (rst_n) begin
            if (m_req_valid && !in_pkt) begin
                assert (s_req_valid != '0)
                    else value_error("output valid while no channel is valid");
                exp_ch = next_channel(last_exp, s_req_valid);  // mask at packet start
                in_pkt = 1'b1;
            end
            if (m_req_valid && m_req_ready) begin
                assert (chk_ptr[exp_ch] < wr_ptr[exp_ch])
                    else value_error($sformatf("extra beat for channel %0d", exp_ch));
                assert (m_req_beat == src_mem[exp_ch][chk_ptr[exp_ch]])
                    else value_error($sformatf("channel %0d beat %0d differs from source",
                                               exp_ch, chk_ptr[exp_ch]));
                assert (s_req_ready == (CHN'(1) << exp_ch))
                    else value_error($sformatf("ready %b, expected only channel %0d",
                                               s_req_ready, exp_ch));
                chk_ptr[exp_ch]++;
                if (m_req_beat.last) begin
                    pkt_chan.push_back(ready_owner(s_req_ready));  // owner as the DUT saw it
                    last_exp = exp_ch;  // pointer moves on the last beat
                    in_pkt   = 1'b0;
                end
            end
        end
    end

    // ******************************************************************
    // sequence
    // ******************************************************************
    initial begin
        int first_pkt;
        int cycles;
        int n_beats;
        seed        = 18109;
        dma_clk     = 1'b0;
        bp_mode     = 1'b0;
        in_pkt      = 1'b0;
        exp_ch      = 0;
        last_exp    = 0;  // arbiter pointer resets to channel 0
        rst_n       <= 1'b0;
        m_req_ready <= 1'b1;
        s_req_valid <= '0;
        for (int c = 0; c < CHN; c++) begin
            s_req_beat[c] <= '0;
            wr_ptr[c]     = 0;
            rd_ptr[c]     = 0;
            chk_ptr[c]    = 0;
        end
        repeat (4) @(posedge dma_clk);
        rst_n <= 1'b1;
        check_quiet(4);

        // channel 0 alone, pointer stays at 0
        @(negedge dma_clk);
        load_packets(0, 8, 4);
        wait_drain(400, "single-channel packets", cycles);

        // all channels at once, search starts at channel 1
        first_pkt = pkt_chan.size();
        @(negedge dma_clk);
        for (int c = 0; c < CHN; c++)
            load_packets(c, 5, 4);
        wait_drain(600, "all-channel packets", cycles);
        assert (pkt_chan[first_pkt] == 1)
            else value_error($sformatf("first grant went to channel %0d",
                                       pkt_chan[first_pkt]));

        // random back-pressure
        @(negedge dma_clk);
        bp_mode = 1'b1;
        for (int c = 0; c < CHN; c++)
            load_packets(c, 5, 4);
        wait_drain(1500, "packets under back-pressure", cycles);
        bp_mode = 1'b0;

        // one-beat packets back to back
        @(negedge dma_clk);
        n_beats = CHN * 3;
        for (int c = 0; c < CHN; c++)
            load_packets(c, 3, 1);
        wait_drain(100, "one-beat packets", cycles);
        assert (cycles <= n_beats + 3)
            else value_error($sformatf("%0d one-beat packets took %0d cycles",
                                       n_beats, cycles));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: filelist.f
dma_req_pkg.sv
req_rr_select.sv
req_arb_fsm.sv
req_beat_mux.sv
req_arbiter.sv
req_arbiter_assert.sv
tb_req_arbiter.sv

// File: run_sim.sh
#!/bin/sh
# build and run the request arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_req_arbiter
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
